/* design/eth_rx_defs.svh */
`ifndef ETH_RX_DEFS_SVH
`define ETH_RX_DEFS_SVH

// Inter-frame gap in nibble times
`define RX_IFG_NIBBLES 24

// Shortest legal frame in bytes, FCS included
`define RX_MIN_FRAME 64

// CRC register after a good frame, FCS included
`define RX_CRC_RESIDUE 32'hdebb20e3

// FIFO depths, powers of two
`define RX_DATA_DEPTH 64
`define RX_STAT_DEPTH 4

`endif

/* design/eth_rx_pkg.sv */
`default_nettype none

package eth_rx_pkg;

  // One-hot receive state
  typedef struct packed {
    logic idle;
    logic preamble;
    logic sfd;
    logic data;
    logic drop;
  } rxStateT;

  typedef struct packed {
    logic [7:0] data;
    logic       last;       // Final byte of the frame
  } rxByteT;

  typedef struct packed {
    logic [15:0] length;
    logic        crcErr;
    logic        tooLong;
    logic        tooShort;
  } rxStatusT;

  typedef struct packed {
    logic [15:0] byteCnt;
    logic        ifgOk;     // Gap long enough for a new frame
    logic        maxFrame;
  } rxCountT;

endpackage

`default_nettype wire

/* design/ethRxStateMachine.sv */
`default_nettype none
`include "eth_rx_defs.svh"

module ethRxStateMachine
  import eth_rx_pkg::*;
(
  input  wire          MRxClk,
  input  wire          Reset,
  input  wire    [3:0] MRxD,
  input  wire          MRxDV,
  input  wire rxCountT rxCount,
  input  wire          crcErr,
  output rxStateT      rxState,
  output logic         byteValid,
  output rxByteT       rxByte,
  output logic         frameEnd,
  output rxStatusT     status,
  output logic         statusPush
);
  rxStateT    stateNext;
  logic       endNow;
  logic       highNibble;
  logic       pendValid;
  logic [3:0] lowNib;
  logic [7:0] pendByte;

  always_comb
  begin
    stateNext = '0;
    endNow    = 1'b0;
    if (rxState.idle)
    begin
      if (MRxDV && MRxD == 4'h5)
        stateNext.preamble = 1'b1;
      else if (MRxDV)
        stateNext.drop = 1'b1;          // Joined mid-frame
      else
        stateNext.idle = 1'b1;
    end
    else if (rxState.preamble)
    begin
      if (!MRxDV)
        stateNext.idle = 1'b1;
      else if (MRxD == 4'hd)
      begin
        stateNext.sfd  = rxCount.ifgOk;
        stateNext.drop = ~rxCount.ifgOk; // Gap too short
      end
      else if (MRxD == 4'h5)
        stateNext.preamble = 1'b1;
      else
        stateNext.drop = 1'b1;
    end
    else if (rxState.sfd || rxState.data)
    begin
      stateNext.data = MRxDV;
      stateNext.idle = ~MRxDV;
      endNow         = rxState.data & ~MRxDV;
    end
    else
    begin
      stateNext.drop = MRxDV;
      stateNext.idle = ~MRxDV;
    end
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      rxState    <= '{idle: 1'b1, default: 1'b0};
      highNibble <= 1'b0;
      pendValid  <= 1'b0;
      byteValid  <= 1'b0;
      frameEnd   <= 1'b0;
    end
    else
    begin
      rxState   <= stateNext;
      frameEnd  <= endNow;
      byteValid <= pendValid;           // Wait one nibble to learn last
      pendValid <= rxState.data & MRxDV & highNibble;
      if (!(rxState.sfd || rxState.data))
        highNibble <= 1'b0;
      else if (MRxDV)
        highNibble <= ~highNibble;
    end
  end

  always_ff @(posedge MRxClk)
  begin
    if (MRxDV && !highNibble)
      lowNib <= MRxD;
    if (MRxDV && highNibble)
      pendByte <= {MRxD, lowNib};
    if (pendValid)
    begin
      rxByte.data <= pendByte;
      rxByte.last <= ~MRxDV;
    end
  end

  always_comb
  begin
    status.length   = rxCount.byteCnt;
    status.crcErr   = crcErr;
    status.tooLong  = rxCount.maxFrame;
    status.tooShort = rxCount.byteCnt < 16'(`RX_MIN_FRAME);
  end

  assign statusPush = frameEnd;

endmodule

`default_nettype wire

/* design/ethRxCounters.sv */
`default_nettype none
`include "eth_rx_defs.svh"

module ethRxCounters
  import eth_rx_pkg::*;
(
  input  wire          MRxClk,
  input  wire          Reset,
  input  wire          MRxDV,
  input  wire rxStateT rxState,
  input  wire   [15:0] maxFrameLen,
  input  wire          hugeEnable,
  input  wire          ifgIgnore,
  output rxCountT      rxCount
);
  logic [15:0] byteCnt;
  logic        highNibble;
  logic        maxFrameQ;
  logic [7:0]  ifgCnt;
  logic        inFrame;
  logic        atMaxLen;
  logic        byteTick;
  logic        ifgSat;

  assign inFrame  = rxState.sfd | rxState.data;
  assign atMaxLen = (byteCnt == maxFrameLen) & ~hugeEnable;
  assign byteTick = rxState.data & MRxDV & highNibble;  // High nibble closes a byte
  assign ifgSat   = ifgCnt == 8'(`RX_IFG_NIBBLES);

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      byteCnt    <= 16'h0;
      highNibble <= 1'b0;
      maxFrameQ  <= 1'b0;
    end
    else
    begin
      if (!inFrame)
        highNibble <= 1'b0;
      else if (MRxDV)
        highNibble <= ~highNibble;
      if (rxState.sfd)
      begin
        byteCnt   <= 16'h0;
        maxFrameQ <= 1'b0;
      end
      else if (byteTick)
      begin
        if (atMaxLen)
          maxFrameQ <= 1'b1;            // Byte beyond the limit
        else if (byteCnt != 16'hffff)
          byteCnt <= byteCnt + 16'd1;
      end
    end
  end

  // Idle nibbles since the last frame
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      ifgCnt <= 8'(`RX_IFG_NIBBLES);
    else if ((inFrame || rxState.drop) && MRxDV)
      ifgCnt <= 8'h0;
    else if (!MRxDV && !ifgSat)
      ifgCnt <= ifgCnt + 8'd1;
  end

  assign rxCount = '{byteCnt: byteCnt, ifgOk: ifgSat | ifgIgnore, maxFrame: maxFrameQ};

endmodule

`default_nettype wire

/* design/ethRxCrcCheck.sv */
`default_nettype none
`include "eth_rx_defs.svh"

module ethRxCrcCheck
  import eth_rx_pkg::*;
(
  input  wire          MRxClk,
  input  wire          Reset,
  input  wire    [3:0] MRxD,
  input  wire          MRxDV,
  input  wire rxStateT rxState,
  input  wire          frameEnd,
  output logic         crcErr
);
  localparam logic [31:0] crcPoly = 32'hedb88320;  // Reflected CRC-32

  logic [31:0] crc;
  logic        crcErrQ;
  logic        mismatch;

  // LSB of the nibble goes in first
  function automatic logic [31:0] crcNibble(input logic [31:0] crcIn, input logic [3:0] nib);
    logic [31:0] c;
    c = crcIn;
    for (int i = 0; i < 4; i++)
    begin
      if (c[0] ^ nib[i])
        c = (c >> 1) ^ crcPoly;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      crc     <= '1;
      crcErrQ <= 1'b0;
    end
    else
    begin
      if ((rxState.sfd || rxState.data) && MRxDV)
        crc <= crcNibble(rxState.sfd ? '1 : crc, MRxD);  // Preset on first nibble
      if (frameEnd)
        crcErrQ <= mismatch;
      else if (rxState.sfd)
        crcErrQ <= 1'b0;
    end
  end

  assign mismatch = crc != `RX_CRC_RESIDUE;
  assign crcErr   = frameEnd ? mismatch : crcErrQ;

endmodule

`default_nettype wire

/* design/ethRxFifo.sv */
`default_nettype none

module ethRxFifo #(
  parameter type payloadT = logic [7:0],
  parameter int  depth    = 4
)
(
  input  wire          MRxClk,
  input  wire          Reset,
  input  wire          push,
  input  wire payloadT pushData,
  input  wire          pop,
  output payloadT      popData,
  output logic         empty,
  output logic         full
);
  localparam int ptrWidth = $clog2(depth);

  payloadT             mem [depth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0]   count;
  logic                doPush;
  logic                doPop;

  assign doPush  = push & ~full;        // Full FIFO drops the entry
  assign doPop   = pop & ~empty;
  assign empty   = count == '0;
  assign full    = int'(count) == depth;
  assign popData = mem[rdPtr];

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;          // Depth is a power of two
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      if (doPush && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doPush)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge MRxClk)
  begin
    if (doPush)
      mem[wrPtr] <= pushData;
  end

endmodule

`default_nettype wire

/* design/ethRxWbPort.sv */
`default_nettype none

module ethRxWbPort
  import eth_rx_pkg::*;
(
  input  wire           MRxClk,
  input  wire           Reset,
  input  wire           wbCyc,
  input  wire           wbStb,
  input  wire           wbWe,
  input  wire           wbAdr,
  input  wire    [31:0] wbDatI,
  output logic   [31:0] wbDatO,
  output logic          wbAck,
  input  wire rxStatusT statData,
  input  wire           statEmpty,
  output logic          statPop,
  input  wire rxByteT   byteData,
  input  wire           byteEmpty,
  output logic          bytePop
);
  logic        newReq;
  logic        readReq;
  logic [31:0] readWord;

  assign newReq  = wbCyc & wbStb & ~wbAck;  // Ack cycle starts nothing
  assign readReq = newReq & ~wbWe;
  assign statPop = readReq & ~wbAdr & ~statEmpty;
  assign bytePop = readReq & wbAdr & ~byteEmpty;

  always_comb
  begin
    readWord = '0;
    if (!wbAdr && !statEmpty)
    begin
      readWord[31]   = 1'b1;
      readWord[18:0] = statData;
    end
    else if (wbAdr && !byteEmpty)
    begin
      readWord[31]  = 1'b1;
      readWord[8]   = byteData.last;
      readWord[7:0] = byteData.data;
    end
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      wbAck <= 1'b0;
    else
      wbAck <= newReq;
  end

  always_ff @(posedge MRxClk)
  begin
    if (newReq)
      wbDatO <= wbWe ? '0 : readWord;   // Write data has no target
  end

endmodule

`default_nettype wire

/* design/ethRxTop.sv */
`default_nettype none
`include "eth_rx_defs.svh"

module ethRxTop
  import eth_rx_pkg::*;
(
  input  wire         MRxClk,
  input  wire         Reset,
  input  wire   [3:0] MRxD,
  input  wire         MRxDV,
  input  wire  [15:0] maxFrameLen,
  input  wire         hugeEnable,
  input  wire         ifgIgnore,
  input  wire         wbCyc,
  input  wire         wbStb,
  input  wire         wbWe,
  input  wire         wbAdr,
  input  wire  [31:0] wbDatI,
  output logic [31:0] wbDatO,
  output logic        wbAck
);
  rxStateT  rxState;
  rxCountT  rxCount;
  rxByteT   rxByte;
  rxByteT   byteHead;
  rxStatusT status;
  rxStatusT statHead;
  logic     byteValid;
  logic     frameEnd;
  logic     crcErr;
  logic     statusPush;
  logic     byteEmpty;
  logic     byteFull;
  logic     bytePop;
  logic     statEmpty;
  logic     statFull;
  logic     statPop;

  ethRxStateMachine stateMachine (
    .MRxClk     (MRxClk),
    .Reset      (Reset),
    .MRxD       (MRxD),
    .MRxDV      (MRxDV),
    .rxCount    (rxCount),
    .crcErr     (crcErr),
    .rxState    (rxState),
    .byteValid  (byteValid),
    .rxByte     (rxByte),
    .frameEnd   (frameEnd),
    .status     (status),
    .statusPush (statusPush)
  );

  ethRxCounters counters (
    .MRxClk      (MRxClk),
    .Reset       (Reset),
    .MRxDV       (MRxDV),
    .rxState     (rxState),
    .maxFrameLen (maxFrameLen),
    .hugeEnable  (hugeEnable),
    .ifgIgnore   (ifgIgnore),
    .rxCount     (rxCount)
  );

  ethRxCrcCheck crcCheck (
    .MRxClk   (MRxClk),
    .Reset    (Reset),
    .MRxD     (MRxD),
    .MRxDV    (MRxDV),
    .rxState  (rxState),
    .frameEnd (frameEnd),
    .crcErr   (crcErr)
  );

  ethRxFifo #(
    .payloadT (rxByteT),
    .depth    (`RX_DATA_DEPTH)
  ) dataFifo (
    .MRxClk   (MRxClk),
    .Reset    (Reset),
    .push     (byteValid),
    .pushData (rxByte),
    .pop      (bytePop),
    .popData  (byteHead),
    .empty    (byteEmpty),
    .full     (byteFull)
  );

  ethRxFifo #(
    .payloadT (rxStatusT),
    .depth    (`RX_STAT_DEPTH)
  ) statFifo (
    .MRxClk   (MRxClk),
    .Reset    (Reset),
    .push     (statusPush),
    .pushData (status),
    .pop      (statPop),
    .popData  (statHead),
    .empty    (statEmpty),
    .full     (statFull)
  );

  ethRxWbPort wbPort (
    .MRxClk    (MRxClk),
    .Reset     (Reset),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatI    (wbDatI),
    .wbDatO    (wbDatO),
    .wbAck     (wbAck),
    .statData  (statHead),
    .statEmpty (statEmpty),
    .statPop   (statPop),
    .byteData  (byteHead),
    .byteEmpty (byteEmpty),
    .bytePop   (bytePop)
  );

endmodule

`default_nettype wire

/* bench/ethRx_checker.sv */
`default_nettype none

module ethRx_checker (
  input wire MRxClk,
  input wire Reset,
  input wire byteValid,
  input wire lastByte,
  input wire byteFull,
  input wire byteEmpty,
  input wire statusPush,
  input wire statFull,
  input wire statEmpty
);
  int failCount = 0;

  // Bytes of a frame are read only after its status
  statHasData: assert property (@(posedge MRxClk) disable iff (Reset)
    !statEmpty |-> !byteEmpty)
  else
  begin
    $error("Status entry waiting while the data FIFO is empty");
    failCount++;
  end

  noPushFull: assert property (@(posedge MRxClk) disable iff (Reset)
    !(byteValid && byteFull) && !(statusPush && statFull))
  else
  begin
    $error("Push into a full FIFO");
    failCount++;
  end

  pushAtEnd: assert property (@(posedge MRxClk) disable iff (Reset)
    (byteValid && lastByte) == statusPush)
  else
  begin
    $error("Status push not aligned with the last byte push");
    failCount++;
  end

endmodule

bind ethRxTop ethRx_checker assertions (
  .MRxClk     (MRxClk),
  .Reset      (Reset),
  .byteValid  (byteValid),
  .lastByte   (rxByte.last),
  .byteFull   (byteFull),
  .byteEmpty  (byteEmpty),
  .statusPush (statusPush),
  .statFull   (statFull),
  .statEmpty  (statEmpty)
);

`default_nettype wire

/* bench/ethRxMonitor.sv */
`default_nettype none

module ethRxMonitor (
  input  wire         MRxClk,
  input  wire         Reset,
  input  wire  [31:0] wbDatO,
  input  wire         wbAck,
  input  wire         allSent,
  output logic        wbCyc,
  output logic        wbStb,
  output logic        wbWe,
  output logic        wbAdr,
  output logic [31:0] wbDatI,
  output logic        done,
  output int          statErrors,
  output int          dataErrors,
  output int          busErrors
);
  logic [31:0] expStat [$];
  int          expCount [$];
  logic [7:0]  expByte [$];

  task automatic expectFrame(input logic [31:0] statWord, input int nBytes);
    expStat.push_back(statWord);
    expCount.push_back(nBytes);
  endtask

  task automatic expectByte(input logic [7:0] value);
    expByte.push_back(value);
  endtask

  // One classic cycle, held until ack
  task automatic busCycle(input logic we, input logic adr, output logic [31:0] rdata);
    int waitCnt;
    waitCnt = 0;
    @(negedge MRxClk);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatI = {32{we}};
    @(negedge MRxClk);
    while (!wbAck && waitCnt < 8)
    begin
      @(negedge MRxClk);
      waitCnt++;
    end
    if (!wbAck)
    begin
      busErrors++;
      $display("Bus cycle at address %0d was never acknowledged", adr);
    end
    rdata = wbDatO;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic checkFrame(input logic [31:0] statWord);
    logic [31:0] exp;
    logic [31:0] got;
    int          nBytes;
    if (expStat.size() == 0)
    begin
      statErrors++;
      $display("Status word %08h arrived while no frame was expected", statWord);
      return;
    end
    exp    = expStat.pop_front();
    nBytes = expCount.pop_front();
    if (statWord !== exp)
    begin
      statErrors++;
      $display("FAILED wbDatO (status): got %08h, expected %08h", statWord, exp);
    end
    busCycle(1'b1, 1'b1, got);         // Write must leave the bytes in place
    for (int i = 0; i < nBytes; i++)
    begin
      busCycle(1'b0, 1'b1, got);
      exp = {1'b1, 22'h0, i == nBytes - 1, expByte.pop_front()};  // Valid, last, byte
      if (got !== exp)
      begin
        dataErrors++;
        $display("FAILED wbDatO (byte %0d): got %08h, expected %08h", i, got, exp);
      end
    end
  endtask

  initial
  begin
    logic [31:0] word;
    wbCyc      = 1'b0;
    wbStb      = 1'b0;
    wbWe       = 1'b0;
    wbAdr      = 1'b0;
    wbDatI     = 32'h0;
    done       = 1'b0;
    statErrors = 0;
    dataErrors = 0;
    busErrors  = 0;
    @(negedge Reset);
    while (!(allSent && expStat.size() == 0))
    begin
      busCycle(1'b0, 1'b0, word);      // Poll status
      if (word[31])
        checkFrame(word);
    end
    busCycle(1'b1, 1'b0, word);
    busCycle(1'b1, 1'b1, word);
    busCycle(1'b0, 1'b0, word);
    if (word !== 32'h0)
    begin
      statErrors++;
      $display("FAILED wbDatO (empty status): got %08h, expected %08h", word, 32'h0);
    end
    busCycle(1'b0, 1'b1, word);
    if (word !== 32'h0)
    begin
      dataErrors++;
      $display("FAILED wbDatO (empty data): got %08h, expected %08h", word, 32'h0);
    end
    done = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/ethRxTb.sv */
`default_nettype none

module ethRxTb;
  localparam int maxFrames = 16;
  localparam int maxBytes  = 64;

  typedef struct packed {
    logic [15:0] gap;
    logic [15:0] nBytes;
    logic        corrupt;
    logic [15:0] maxLen;
    logic        huge;
    logic        ifgIgn;
    logic [15:0] expLen;
    logic        expCrc;
    logic        expLong;
    logic        expShort;
    logic        dropped;
  } frameRecT;

  logic        MRxClk;
  logic        Reset;
  logic [3:0]  MRxD;
  logic        MRxDV;
  logic [15:0] maxFrameLen;
  logic        hugeEnable;
  logic        ifgIgnore;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic        wbAdr;
  logic [31:0] wbDatI;
  logic [31:0] wbDatO;
  logic        wbAck;
  logic        allSent;
  logic        done;
  int          statErrors;
  int          dataErrors;
  int          busErrors;
  int          setupErrors;
  int          cycles;
  int          cycleLimit;
  int          numFrames;
  logic [31:0] rngState;
  frameRecT    recs [maxFrames];

  ethRxTop ethRxTop_inst (
    .MRxClk      (MRxClk),
    .Reset       (Reset),
    .MRxD        (MRxD),
    .MRxDV       (MRxDV),
    .maxFrameLen (maxFrameLen),
    .hugeEnable  (hugeEnable),
    .ifgIgnore   (ifgIgnore),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbWe        (wbWe),
    .wbAdr       (wbAdr),
    .wbDatI      (wbDatI),
    .wbDatO      (wbDatO),
    .wbAck       (wbAck)
  );

  ethRxMonitor monitor (
    .MRxClk     (MRxClk),
    .Reset      (Reset),
    .wbDatO     (wbDatO),
    .wbAck      (wbAck),
    .allSent    (allSent),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbDatI     (wbDatI),
    .done       (done),
    .statErrors (statErrors),
    .dataErrors (dataErrors),
    .busErrors  (busErrors)
  );

  initial
  begin
    MRxClk = 1'b0;
    forever #2 MRxClk = ~MRxClk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Ethernet CRC-32, one byte LSB first
  function automatic logic [31:0] crcByte(input logic [31:0] c, input logic [7:0] b);
    logic [31:0] r;
    r = c ^ {24'h0, b};
    for (int i = 0; i < 8; i++)
      r = r[0] ? (r >> 1) ^ 32'hedb88320 : r >> 1;
    return r;
  endfunction

  task automatic loadStimulus();
    int    fd;
    int    n;
    int    f [11];
    string line;
    numFrames = 0;
    fd = $fopen("bench/eth_rx_stimulus.txt", "r");
    if (fd == 0)
    begin
      setupErrors++;
      $display("Could not open the stimulus file");
      return;
    end
    while (!$feof(fd) && numFrames < maxFrames)
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] != "#")
      begin
        n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2], f[3],
                    f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
        if (n == 11 && f[1] >= 5 && f[1] <= maxBytes)
        begin
          recs[numFrames].gap      = 16'(f[0]);
          recs[numFrames].nBytes   = 16'(f[1]);
          recs[numFrames].corrupt  = f[2] != 0;
          recs[numFrames].maxLen   = 16'(f[3]);
          recs[numFrames].huge     = f[4] != 0;
          recs[numFrames].ifgIgn   = f[5] != 0;
          recs[numFrames].expLen   = 16'(f[6]);
          recs[numFrames].expCrc   = f[7] != 0;
          recs[numFrames].expLong  = f[8] != 0;
          recs[numFrames].expShort = f[9] != 0;
          recs[numFrames].dropped  = f[10] != 0;
          numFrames++;
        end
        else if (n > 0)
        begin
          setupErrors++;
          $display("Stimulus line could not be used: %s", line);
        end
      end
    end
    $fclose(fd);
    if (numFrames == 0)
    begin
      setupErrors++;
      $display("The stimulus file holds no frames");
    end
  endtask

  task automatic sendNibble(input logic [3:0] nib, input logic dv);
    @(negedge MRxClk);
    MRxD  = nib;
    MRxDV = dv;
  endtask

  task automatic runFrame(input frameRecT r);
    logic [7:0]  bytes [maxBytes];
    logic [31:0] crc;
    logic [31:0] fcs;
    int          nPay;
    nPay = r.nBytes - 4;
    crc  = '1;
    for (int i = 0; i < nPay; i++)
    begin
      rngState = xorshift(rngState);
      bytes[i] = rngState[7:0];
      crc      = crcByte(crc, bytes[i]);
    end
    fcs = ~crc;
    for (int i = 0; i < 4; i++)
      bytes[nPay + i] = fcs[8*i +: 8];
    if (r.corrupt)
      bytes[nPay] ^= 8'h01;            // Low FCS nibble
    if (!r.dropped)
    begin
      monitor.expectFrame({1'b1, 12'h0, r.expLen, r.expCrc, r.expLong, r.expShort}, r.nBytes);
      for (int i = 0; i < r.nBytes; i++)
        monitor.expectByte(bytes[i]);
    end
    sendNibble(4'h0, 1'b0);
    maxFrameLen = r.maxLen;            // Settles after the last frame closed
    hugeEnable  = r.huge;
    ifgIgnore   = r.ifgIgn;
    for (int i = 1; i < r.gap; i++)
      sendNibble(4'h0, 1'b0);
    for (int i = 0; i < 15; i++)
      sendNibble(4'h5, 1'b1);
    sendNibble(4'hd, 1'b1);
    for (int i = 0; i < r.nBytes; i++)
    begin
      sendNibble(bytes[i][3:0], 1'b1);
      sendNibble(bytes[i][7:4], 1'b1);
    end
  endtask

  task automatic printCounts();
    $display("Error counts: status %0d, data %0d, bus %0d, assertion %0d, setup %0d",
             statErrors, dataErrors, busErrors, ethRxTop_inst.assertions.failCount,
             setupErrors);
  endtask

  always @(posedge MRxClk)
  begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit)
    begin
      $display("Timeout after %0d cycles, the receive run did not finish", cycles);
      printCounts();
      $display(">>> FAIL");
      $finish;
    end
  end

  initial
  begin
    int total;
    MRxD        = 4'h0;
    MRxDV       = 1'b0;
    maxFrameLen = 16'd1518;
    hugeEnable  = 1'b0;
    ifgIgnore   = 1'b0;
    Reset       = 1'b1;
    allSent     = 1'b0;
    setupErrors = 0;
    cycles      = 0;
    cycleLimit  = 0;
    rngState    = 32'd5086;
    loadStimulus();
    total = 16;
    for (int i = 0; i < numFrames; i++)
      total += recs[i].gap + 16 + 2 * recs[i].nBytes + 200;
    cycleLimit = total + 200;           // Reset, final bus checks
    repeat (16) @(posedge MRxClk);
    @(negedge MRxClk);
    Reset = 1'b0;
    for (int i = 0; i < numFrames; i++)
      runFrame(recs[i]);
    sendNibble(4'h0, 1'b0);
    allSent = 1'b1;
    wait (done);
    printCounts();
    total = statErrors + dataErrors + busErrors + setupErrors;
    total += ethRxTop_inst.assertions.failCount;
    if (total == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/eth_rx_pkg.sv
design/ethRxStateMachine.sv
design/ethRxCounters.sv
design/ethRxCrcCheck.sv
design/ethRxFifo.sv
design/ethRxWbPort.sv
design/ethRxTop.sv
bench/ethRx_checker.sv
bench/ethRxMonitor.sv
bench/ethRxTb.sv

/* bench/eth_rx_stimulus.txt */
# gap nBytes corrupt maxFrameLen hugeEnable ifgIgnore expLen expCrcErr expTooLong expTooShort dropped
# nBytes counts the FCS, gap is idle nibbles before the preamble, payload comes from xorshift
30 64 0 1518 0 0 64 0 0 0 0
30 64 1 1518 0 0 64 1 0 0 0
30 40 0 1518 0 0 40 0 0 1 0
30 64 0 60 0 0 60 0 1 1 0
30 64 0 60 1 0 64 0 0 0 0
10 64 0 1518 0 0 0 0 0 0 1
10 64 0 1518 0 1 64 0 0 0 0
30 48 0 1518 0 0 48 0 0 1 0
